// File: chip8_pkg.sv
package chip8_pkg;

  localparam int ADDR_W = 12;
  localparam int DATA_W = 8;
  localparam int REG_SEL_W = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] byte_t;

  typedef enum logic [1:0] {
    FETCH_HI = 2'd0,
    FETCH_LO = 2'd1,
    EXEC     = 2'd2,
    HALT     = 2'd3
  } seq_state_e;

  // low nibble of the 8xy group
  typedef enum logic [3:0] {
    ALU_LD   = 4'h0,
    ALU_OR   = 4'h1,
    ALU_AND  = 4'h2,
    ALU_XOR  = 4'h3,
    ALU_ADD  = 4'h4,
    ALU_SUB  = 4'h5,
    ALU_SHR  = 4'h6,
    ALU_SUBN = 4'h7,
    ALU_SHL  = 4'hE
  } alu_op_e;

  typedef struct packed {
    logic [3:0] opc;
    addr_t      addr;
  } instr_nnn_t;

  typedef struct packed {
    logic [3:0]           opc;
    logic [REG_SEL_W-1:0] x;
    byte_t                kk;
  } instr_xkk_t;

  typedef struct packed {
    logic [3:0]           opc;
    logic [REG_SEL_W-1:0] x;
    logic [REG_SEL_W-1:0] y;
    logic [3:0]           n;
  } instr_xyn_t;

  typedef union packed {
    instr_nnn_t nnn;
    instr_xkk_t xkk;
    instr_xyn_t xyn;
  } instr_u;

  localparam logic [3:0] OPC_SYS   = 4'h0;
  localparam logic [3:0] OPC_JP    = 4'h1;
  localparam logic [3:0] OPC_CALL  = 4'h2;
  localparam logic [3:0] OPC_SE    = 4'h3;
  localparam logic [3:0] OPC_SNE   = 4'h4;
  localparam logic [3:0] OPC_SE_V  = 4'h5;
  localparam logic [3:0] OPC_LD    = 4'h6;
  localparam logic [3:0] OPC_ADD   = 4'h7;
  localparam logic [3:0] OPC_ALU   = 4'h8;
  localparam logic [3:0] OPC_SNE_V = 4'h9;
  localparam logic [3:0] OPC_LD_I  = 4'hA;
  localparam logic [3:0] OPC_KEY   = 4'hE;
  localparam logic [3:0] OPC_MISC  = 4'hF;

  // 00EE as seen through the nnn view
  localparam addr_t SYS_RET = 12'h0EE;

  localparam byte_t EX_SKP      = 8'h9E;
  localparam byte_t EX_SKNP     = 8'hA1;
  localparam byte_t FX_LD_VX_DT = 8'h07;
  localparam byte_t FX_LD_DT    = 8'h15;
  localparam byte_t FX_LD_ST    = 8'h18;
  localparam byte_t FX_ADD_I    = 8'h1E;

endpackage

// File: chip8_vreg_if.sv
`timescale 1ns/100ps

interface chip8_vreg_if;

  logic [chip8_pkg::REG_SEL_W-1:0] x_sel;
  logic [chip8_pkg::REG_SEL_W-1:0] y_sel;
  chip8_pkg::byte_t                vx;
  chip8_pkg::byte_t                vy;

  logic                            wr_en;
  logic [chip8_pkg::REG_SEL_W-1:0] wr_sel;
  chip8_pkg::byte_t                wr_data;

  // flag write, lands in VF after the normal write
  logic                            vf_en;
  chip8_pkg::byte_t                vf_data;

  modport seq (
    output x_sel, y_sel, wr_en, wr_sel, wr_data, vf_en, vf_data,
    input  vx, vy
  );

  modport regs (
    input  x_sel, y_sel, wr_en, wr_sel, wr_data, vf_en, vf_data,
    output vx, vy
  );

endinterface

// File: chip8_regfile.sv
`timescale 1ns/100ps

module chip8_regfile (
  input logic        clk,
  input logic        reset_i,
  chip8_vreg_if.regs vreg
);

  localparam int NUM_REGS = 2 ** chip8_pkg::REG_SEL_W;
  localparam logic [chip8_pkg::REG_SEL_W-1:0] VF_SEL = chip8_pkg::REG_SEL_W'(NUM_REGS - 1);

  chip8_pkg::byte_t regs_q [NUM_REGS];

  assign vreg.vx = regs_q[vreg.x_sel];
  assign vreg.vy = regs_q[vreg.y_sel];

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        regs_q[i] <= '0;
      end
    end
    else
    begin
      if (vreg.wr_en)
      begin
        regs_q[vreg.wr_sel] <= vreg.wr_data;
      end
      // flag overrides a result aimed at VF
      if (vreg.vf_en)
      begin
        regs_q[VF_SEL] <= vreg.vf_data;
      end
    end
  end

endmodule

// File: chip8_alu.sv
`timescale 1ns/100ps

module chip8_alu (
  input  chip8_pkg::byte_t   vx_i,
  input  chip8_pkg::byte_t   vy_i,
  input  chip8_pkg::alu_op_e alu_op_i,
  output chip8_pkg::byte_t   result_o,
  output logic               flag_o,
  output logic               flag_en_o,
  output logic               illegal_o
);

  logic [chip8_pkg::DATA_W:0] sum_w;

  assign sum_w = {1'b0, vx_i} + {1'b0, vy_i};

  always_comb
  begin
    result_o  = vx_i;
    flag_o    = 1'b0;
    flag_en_o = 1'b0;
    illegal_o = 1'b0;
    case (alu_op_i)
      chip8_pkg::ALU_LD:  result_o = vy_i;
      chip8_pkg::ALU_OR:  result_o = vx_i | vy_i;
      chip8_pkg::ALU_AND: result_o = vx_i & vy_i;
      chip8_pkg::ALU_XOR: result_o = vx_i ^ vy_i;
      chip8_pkg::ALU_ADD:
      begin
        result_o  = sum_w[chip8_pkg::DATA_W-1:0];
        flag_o    = sum_w[chip8_pkg::DATA_W];
        flag_en_o = 1'b1;
      end
      chip8_pkg::ALU_SUB:
      begin
        result_o  = vx_i - vy_i;
        flag_o    = vx_i >= vy_i;
        flag_en_o = 1'b1;
      end
      chip8_pkg::ALU_SHR:
      begin
        result_o  = vx_i >> 1;
        flag_o    = vx_i[0];
        flag_en_o = 1'b1;
      end
      chip8_pkg::ALU_SUBN:
      begin
        result_o  = vy_i - vx_i;
        flag_o    = vy_i >= vx_i;
        flag_en_o = 1'b1;
      end
      chip8_pkg::ALU_SHL:
      begin
        result_o  = vx_i << 1;
        flag_o    = vx_i[chip8_pkg::DATA_W-1];
        flag_en_o = 1'b1;
      end
      default: illegal_o = 1'b1;
    endcase
  end

endmodule

// File: chip8_timers.sv
`timescale 1ns/100ps

module chip8_timers (
  input  logic             clk,
  input  logic             reset_i,
  input  logic             vsync_i,
  input  logic             load_dt_i,
  input  logic             load_st_i,
  input  chip8_pkg::byte_t load_val_i,
  output chip8_pkg::byte_t dt_o,
  output logic             beep_o
);

  logic             vsync_q;
  logic             tick;
  chip8_pkg::byte_t dt_q;
  chip8_pkg::byte_t st_q;

  assign tick   = vsync_i && !vsync_q;
  assign dt_o   = dt_q;
  assign beep_o = st_q != '0;

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      vsync_q <= 1'b0;
      dt_q    <= '0;
      st_q    <= '0;
    end
    else
    begin
      vsync_q <= vsync_i;
      // a load in the same cycle as a tick takes the new value
      if (load_dt_i)
        dt_q <= load_val_i;
      else if (tick && dt_q != '0)
        dt_q <= dt_q - 1'b1;
      if (load_st_i)
        st_q <= load_val_i;
      else if (tick && st_q != '0)
        st_q <= st_q - 1'b1;
    end
  end

endmodule

// File: chip8_seq.sv
`timescale 1ns/100ps

module chip8_seq #(
  parameter chip8_pkg::addr_t START_ADDR = 12'h200,
  parameter int STACK_DEPTH = 8
) (
  input  logic               clk,
  input  logic               reset_i,
  output logic               prog_rd_o,
  output chip8_pkg::addr_t   prog_addr_o,
  input  chip8_pkg::byte_t   prog_data_i,
  input  logic [15:0]        keys_i,
  chip8_vreg_if.seq          vreg,
  output chip8_pkg::alu_op_e alu_op_o,
  input  chip8_pkg::byte_t   alu_result_i,
  input  logic               alu_flag_i,
  input  logic               alu_flag_en_i,
  input  logic               alu_illegal_i,
  output logic               load_dt_o,
  output logic               load_st_o,
  output chip8_pkg::byte_t   load_val_o,
  input  chip8_pkg::byte_t   dt_i,
  output logic               halted_o
);

  localparam int SP_W = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;

  chip8_pkg::seq_state_e state_q;
  chip8_pkg::addr_t      pc_q;
  chip8_pkg::addr_t      i_q;
  chip8_pkg::byte_t      ir_hi_q;
  chip8_pkg::addr_t      stack_q [STACK_DEPTH];
  logic [SP_W-1:0]       sp_q;
  logic [SP_W-1:0]       sp_inc;
  logic [SP_W-1:0]       sp_dec;

  chip8_pkg::instr_u instr;
  chip8_pkg::addr_t  pc_next;
  chip8_pkg::addr_t  i_next;
  chip8_pkg::byte_t  wr_data;
  logic              exec;
  logic              legal;
  logic              commit;
  logic              skip;
  logic              push;
  logic              pop;
  logic              wr_en;
  logic              vf_en;
  logic              load_dt;
  logic              load_st;

  // low byte arrives in EXEC straight from memory
  assign instr = {ir_hi_q, prog_data_i};

  assign exec   = state_q == chip8_pkg::EXEC;
  assign commit = exec && legal;

  assign prog_rd_o   = state_q == chip8_pkg::FETCH_HI || state_q == chip8_pkg::FETCH_LO;
  assign prog_addr_o = (state_q == chip8_pkg::FETCH_LO) ? pc_q + 1'b1 : pc_q;
  assign halted_o    = state_q == chip8_pkg::HALT;

  assign sp_inc = (sp_q == SP_W'(STACK_DEPTH - 1)) ? '0 : sp_q + 1'b1;
  assign sp_dec = (sp_q == '0) ? SP_W'(STACK_DEPTH - 1) : sp_q - 1'b1;

  assign vreg.x_sel   = instr.xkk.x;
  assign vreg.y_sel   = instr.xyn.y;
  assign vreg.wr_sel  = instr.xkk.x;
  assign vreg.wr_en   = commit && wr_en;
  assign vreg.wr_data = wr_data;
  assign vreg.vf_en   = commit && vf_en;
  assign vreg.vf_data = chip8_pkg::byte_t'(alu_flag_i);

  assign alu_op_o   = chip8_pkg::alu_op_e'(instr.xyn.n);
  assign load_dt_o  = commit && load_dt;
  assign load_st_o  = commit && load_st;
  assign load_val_o = vreg.vx;

  always_comb
  begin
    legal   = 1'b1;
    skip    = 1'b0;
    push    = 1'b0;
    pop     = 1'b0;
    wr_en   = 1'b0;
    vf_en   = 1'b0;
    load_dt = 1'b0;
    load_st = 1'b0;
    wr_data = instr.xkk.kk;
    i_next  = i_q;
    pc_next = pc_q + 12'd2;
    case (instr.nnn.opc)
      chip8_pkg::OPC_SYS:
      begin
        legal   = instr.nnn.addr == chip8_pkg::SYS_RET;
        pop     = 1'b1;
        pc_next = stack_q[sp_dec];
      end
      chip8_pkg::OPC_JP:    pc_next = instr.nnn.addr;
      chip8_pkg::OPC_CALL:
      begin
        push    = 1'b1;
        pc_next = instr.nnn.addr;
      end
      chip8_pkg::OPC_SE:    skip = vreg.vx == instr.xkk.kk;
      chip8_pkg::OPC_SNE:   skip = vreg.vx != instr.xkk.kk;
      chip8_pkg::OPC_SE_V:
      begin
        legal = instr.xyn.n == 4'h0;
        skip  = vreg.vx == vreg.vy;
      end
      chip8_pkg::OPC_LD:    wr_en = 1'b1;
      chip8_pkg::OPC_ADD:
      begin
        wr_en   = 1'b1;
        wr_data = vreg.vx + instr.xkk.kk;
      end
      chip8_pkg::OPC_ALU:
      begin
        legal   = !alu_illegal_i;
        wr_en   = 1'b1;
        vf_en   = alu_flag_en_i;
        wr_data = alu_result_i;
      end
      chip8_pkg::OPC_SNE_V:
      begin
        legal = instr.xyn.n == 4'h0;
        skip  = vreg.vx != vreg.vy;
      end
      chip8_pkg::OPC_LD_I:  i_next = instr.nnn.addr;
      chip8_pkg::OPC_KEY:
      begin
        // key index is the low nibble of Vx
        case (instr.xkk.kk)
          chip8_pkg::EX_SKP:  skip = keys_i[vreg.vx[3:0]];
          chip8_pkg::EX_SKNP: skip = !keys_i[vreg.vx[3:0]];
          default:            legal = 1'b0;
        endcase
      end
      chip8_pkg::OPC_MISC:
      begin
        case (instr.xkk.kk)
          chip8_pkg::FX_LD_VX_DT:
          begin
            wr_en   = 1'b1;
            wr_data = dt_i;
          end
          chip8_pkg::FX_LD_DT: load_dt = 1'b1;
          chip8_pkg::FX_LD_ST: load_st = 1'b1;
          chip8_pkg::FX_ADD_I: i_next = i_q + chip8_pkg::addr_t'(vreg.vx);
          default:             legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
    if (skip)
      pc_next = pc_q + 12'd4;
  end

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      state_q <= chip8_pkg::FETCH_HI;
      pc_q    <= START_ADDR;
      i_q     <= '0;
      sp_q    <= '0;
    end
    else
    begin
      case (state_q)
        chip8_pkg::FETCH_HI: state_q <= chip8_pkg::FETCH_LO;
        chip8_pkg::FETCH_LO: state_q <= chip8_pkg::EXEC;
        chip8_pkg::EXEC:
        begin
          if (legal)
          begin
            state_q <= chip8_pkg::FETCH_HI;
            pc_q    <= pc_next;
            i_q     <= i_next;
            if (push)
              sp_q <= sp_inc;
            else if (pop)
              sp_q <= sp_dec;
          end
          else
            state_q <= chip8_pkg::HALT;
        end
        default: state_q <= chip8_pkg::HALT;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == chip8_pkg::FETCH_LO)
      ir_hi_q <= prog_data_i;
    if (commit && push)
      stack_q[sp_q] <= pc_q + 12'd2;
  end

endmodule

// File: chip8_core.sv
`timescale 1ns/100ps

module chip8_core #(
  parameter chip8_pkg::addr_t START_ADDR = 12'h200,
  parameter int STACK_DEPTH = 8
) (
  input  logic             clk,
  input  logic             reset_i,
  input  logic             vsync_i,
  input  logic [15:0]      keys_i,
  input  chip8_pkg::byte_t prog_data_i,
  output logic             prog_rd_o,
  output chip8_pkg::addr_t prog_addr_o,
  output logic             beep_o,
  output logic             halted_o
);

  chip8_pkg::alu_op_e alu_op;
  chip8_pkg::byte_t   alu_result;
  logic               alu_flag;
  logic               alu_flag_en;
  logic               alu_illegal;
  logic               load_dt;
  logic               load_st;
  chip8_pkg::byte_t   load_val;
  chip8_pkg::byte_t   dt;

  chip8_vreg_if vreg_if ();

  chip8_regfile chip8_regfile_i (
    .clk     (clk),
    .reset_i (reset_i),
    .vreg    (vreg_if.regs)
  );

  chip8_alu chip8_alu_i (
    .vx_i      (vreg_if.vx),
    .vy_i      (vreg_if.vy),
    .alu_op_i  (alu_op),
    .result_o  (alu_result),
    .flag_o    (alu_flag),
    .flag_en_o (alu_flag_en),
    .illegal_o (alu_illegal)
  );

  chip8_timers chip8_timers_i (
    .clk        (clk),
    .reset_i    (reset_i),
    .vsync_i    (vsync_i),
    .load_dt_i  (load_dt),
    .load_st_i  (load_st),
    .load_val_i (load_val),
    .dt_o       (dt),
    .beep_o     (beep_o)
  );

  chip8_seq #(
    .START_ADDR  (START_ADDR),
    .STACK_DEPTH (STACK_DEPTH)
  ) chip8_seq_i (
    .clk           (clk),
    .reset_i       (reset_i),
    .prog_rd_o     (prog_rd_o),
    .prog_addr_o   (prog_addr_o),
    .prog_data_i   (prog_data_i),
    .keys_i        (keys_i),
    .vreg          (vreg_if.seq),
    .alu_op_o      (alu_op),
    .alu_result_i  (alu_result),
    .alu_flag_i    (alu_flag),
    .alu_flag_en_i (alu_flag_en),
    .alu_illegal_i (alu_illegal),
    .load_dt_o     (load_dt),
    .load_st_o     (load_st),
    .load_val_o    (load_val),
    .dt_i          (dt),
    .halted_o      (halted_o)
  );

endmodule

// File: tb_chip8.sv
`timescale 1ns/100ps

module tb_chip8;

  localparam chip8_pkg::addr_t START_ADDR = 12'h200;
  localparam int STACK_DEPTH = 8;
  localparam int FETCH_TIMEOUT = 20;

  logic             clk;
  logic             reset_i;
  logic             vsync_i;
  logic [15:0]      keys_i;
  chip8_pkg::byte_t prog_data_i;
  logic             prog_rd_o;
  chip8_pkg::addr_t prog_addr_o;
  logic             beep_o;
  logic             halted_o;

  chip8_pkg::byte_t mem [4096];
  chip8_pkg::addr_t mem_addr_s;
  logic             mem_rd_s;
  logic             rd_prev;
  logic             used [4096];
  chip8_pkg::addr_t hi;
  int               seed;

  // instruction-level model state
  chip8_pkg::byte_t m_mem [4096];
  chip8_pkg::byte_t m_v [16];
  chip8_pkg::addr_t m_pc;
  chip8_pkg::addr_t m_i;
  chip8_pkg::addr_t m_stack [STACK_DEPTH];
  int               m_sp;
  chip8_pkg::byte_t m_dt;
  chip8_pkg::byte_t m_st;
  logic [15:0]      m_keys;
  logic             m_halt;

  chip8_core #(
    .START_ADDR  (START_ADDR),
    .STACK_DEPTH (STACK_DEPTH)
  ) chip8_core_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .vsync_i     (vsync_i),
    .keys_i      (keys_i),
    .prog_data_i (prog_data_i),
    .prog_rd_o   (prog_rd_o),
    .prog_addr_o (prog_addr_o),
    .beep_o      (beep_o),
    .halted_o    (halted_o)
  );

  always #10 clk = ~clk;

  // byte-wide memory, one cycle read latency
  always @(posedge clk)
  begin
    mem_addr_s = prog_addr_o;
    mem_rd_s   = prog_rd_o;
    #2;
    if (mem_rd_s)
      prog_data_i = mem[mem_addr_s];
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("Error at %0t: %s got %0h expected %0h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s at %0t", msg, $time);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic fill_memory();
    for (int a = 0; a < 4096; a++)
    begin
      mem[a]   = 8'(a) ^ 8'(a >> 4);
      m_mem[a] = mem[a];
      used[a]  = 1'b0;
    end
    hi = START_ADDR;
  endtask

  task automatic put_word(input chip8_pkg::addr_t a, input logic [15:0] w);
    mem[a]             = w[15:8];
    mem[a + 12'd1]     = w[7:0];
    m_mem[a]           = w[15:8];
    m_mem[a + 12'd1]   = w[7:0];
    used[a]            = 1'b1;
    if (a > hi)
      hi = a;
  endtask

  task automatic model_reset();
    for (int r = 0; r < 16; r++)
    begin
      m_v[r] = '0;
    end
    m_pc   = START_ADDR;
    m_i    = '0;
    m_sp   = 0;
    m_dt   = '0;
    m_st   = '0;
    m_halt = 1'b0;
    m_keys = keys_i;
  endtask

  task automatic alu_model(input logic [3:0] op, input chip8_pkg::byte_t vx,
                           input chip8_pkg::byte_t vy, output chip8_pkg::byte_t res,
                           output logic flag, output logic flag_en, output logic ok);
    logic [8:0] sum;
    sum     = {1'b0, vx} + {1'b0, vy};
    res     = vx;
    flag    = 1'b0;
    flag_en = op inside {4'h4, 4'h5, 4'h6, 4'h7, 4'hE};
    ok      = 1'b1;
    case (op)
      4'h0:    res = vy;
      4'h1:    res = vx | vy;
      4'h2:    res = vx & vy;
      4'h3:    res = vx ^ vy;
      4'h4:    {flag, res} = sum;
      4'h5:    {flag, res} = {vx >= vy, vx - vy};
      4'h6:    {flag, res} = {vx[0], vx >> 1};
      4'h7:    {flag, res} = {vy >= vx, vy - vx};
      4'hE:    {flag, res} = {vx[7], vx << 1};
      default: ok = 1'b0;
    endcase
  endtask

  task automatic model_step();
    chip8_pkg::instr_u w;
    chip8_pkg::addr_t  nxt;
    chip8_pkg::byte_t  vx;
    chip8_pkg::byte_t  vy;
    chip8_pkg::byte_t  res;
    logic              flag;
    logic              flag_en;
    logic              ok;
    w   = {m_mem[m_pc], m_mem[m_pc + 12'd1]};
    nxt = m_pc + 12'd2;
    vx  = m_v[w.xkk.x];
    vy  = m_v[w.xyn.y];
    case (w.nnn.opc)
      chip8_pkg::OPC_SYS:
      begin
        if (w.nnn.addr == chip8_pkg::SYS_RET)
        begin
          m_sp = (m_sp + STACK_DEPTH - 1) % STACK_DEPTH;
          nxt  = m_stack[m_sp];
        end
        else
          m_halt = 1'b1;
      end
      chip8_pkg::OPC_JP: nxt = w.nnn.addr;
      chip8_pkg::OPC_CALL:
      begin
        m_stack[m_sp] = m_pc + 12'd2;
        m_sp = (m_sp + 1) % STACK_DEPTH;
        nxt  = w.nnn.addr;
      end
      chip8_pkg::OPC_SE:    if (vx == w.xkk.kk) nxt = nxt + 12'd2;
      chip8_pkg::OPC_SNE:   if (vx != w.xkk.kk) nxt = nxt + 12'd2;
      chip8_pkg::OPC_SE_V:
      begin
        if (w.xyn.n != 4'h0)
          m_halt = 1'b1;
        else if (vx == vy)
          nxt = nxt + 12'd2;
      end
      chip8_pkg::OPC_SNE_V:
      begin
        if (w.xyn.n != 4'h0)
          m_halt = 1'b1;
        else if (vx != vy)
          nxt = nxt + 12'd2;
      end
      chip8_pkg::OPC_LD:    m_v[w.xkk.x] = w.xkk.kk;
      chip8_pkg::OPC_ADD:   m_v[w.xkk.x] = vx + w.xkk.kk;
      chip8_pkg::OPC_ALU:
      begin
        alu_model(w.xyn.n, vx, vy, res, flag, flag_en, ok);
        if (!ok)
          m_halt = 1'b1;
        else
        begin
          m_v[w.xyn.x] = res;
          // VF takes the flag even when it is also the target
          if (flag_en)
            m_v[15] = {7'd0, flag};
        end
      end
      chip8_pkg::OPC_LD_I:  m_i = w.nnn.addr;
      chip8_pkg::OPC_KEY:
      begin
        if (w.xkk.kk == chip8_pkg::EX_SKP && m_keys[vx[3:0]])
          nxt = nxt + 12'd2;
        else if (w.xkk.kk == chip8_pkg::EX_SKNP && !m_keys[vx[3:0]])
          nxt = nxt + 12'd2;
        else if (w.xkk.kk != chip8_pkg::EX_SKP && w.xkk.kk != chip8_pkg::EX_SKNP)
          m_halt = 1'b1;
      end
      chip8_pkg::OPC_MISC:
      begin
        case (w.xkk.kk)
          chip8_pkg::FX_LD_VX_DT: m_v[w.xkk.x] = m_dt;
          chip8_pkg::FX_LD_DT:    m_dt = vx;
          chip8_pkg::FX_LD_ST:    m_st = vx;
          chip8_pkg::FX_ADD_I:    m_i = m_i + {4'd0, vx};
          default:                m_halt = 1'b1;
        endcase
      end
      default: m_halt = 1'b1;
    endcase
    if (!m_halt)
      m_pc = nxt;
  endtask

  function automatic logic [15:0] rand_op();
    int         r;
    logic [3:0] k;
    r = $random(seed);
    k = r[19:16] % 4'd9;
    case (r[1:0])
      2'd0:    return {chip8_pkg::OPC_LD, r[7:4], r[15:8]};
      2'd1:    return {chip8_pkg::OPC_ADD, r[7:4], r[15:8]};
      default: return {chip8_pkg::OPC_ALU, r[7:4], r[11:8], (k == 4'd8) ? 4'hE : k};
    endcase
  endfunction

  function automatic logic [15:0] rand_skip(input logic key_mode);
    int               r;
    chip8_pkg::byte_t kk;
    r  = $random(seed);
    // half of the constant skips compare against the live value
    kk = r[10] ? m_v[r[3:0]] : r[23:16];
    if (key_mode)
      return {chip8_pkg::OPC_KEY, r[3:0], r[8] ? chip8_pkg::EX_SKP : chip8_pkg::EX_SKNP};
    case (r[9:8])
      2'd0:    return {chip8_pkg::OPC_SE, r[3:0], kk};
      2'd1:    return {chip8_pkg::OPC_SNE, r[3:0], kk};
      2'd2:    return {chip8_pkg::OPC_SE_V, r[3:0], r[7:4], 4'h0};
      default: return {chip8_pkg::OPC_SNE_V, r[3:0], r[7:4], 4'h0};
    endcase
  endfunction

  task automatic gen_alu_program(input int pairs, input logic key_mode);
    fill_memory();
    model_reset();
    repeat (pairs)
    begin
      put_word(m_pc, rand_op());
      model_step();
      put_word(m_pc, rand_skip(key_mode));
      put_word(m_pc + 12'd2, rand_op());
      model_step();
    end
    put_word(m_pc, 16'h0000);
  endtask

  task automatic gen_flow_program(input int steps);
    int               r;
    int               live;
    chip8_pkg::addr_t fresh;
    fill_memory();
    model_reset();
    live = 0;
    for (int s = 0; s < steps; s++)
    begin
      r = $random(seed);
      fresh = hi + 12'd4 + {7'd0, r[3:0], 1'b0};
      if (!used[m_pc])
      begin
        if (live > 0 && r[5:4] == 2'd0 && s >= 10)
        begin
          put_word(m_pc, 16'h00EE);
          live--;
        end
        else if ((s < 10 || r[5:4] == 2'd1) && !used[m_pc + 12'd2])
        begin
          // the first calls go deeper than the stack to force a wrap
          put_word(m_pc, {chip8_pkg::OPC_CALL, fresh});
          live = (live < STACK_DEPTH) ? live + 1 : STACK_DEPTH;
        end
        else if (r[5:4] == 2'd2 || used[m_pc + 12'd2])
          put_word(m_pc, {chip8_pkg::OPC_JP, fresh});
        else if (r[7:6] == 2'd0)
          put_word(m_pc, {chip8_pkg::OPC_LD_I, r[19:8]});
        else if (r[7:6] == 2'd1)
          put_word(m_pc, {chip8_pkg::OPC_MISC, r[11:8], chip8_pkg::FX_ADD_I});
        else if (r[7:6] == 2'd2)
          put_word(m_pc, {chip8_pkg::OPC_MISC, r[11:8], chip8_pkg::FX_LD_ST});
        else
          put_word(m_pc, {chip8_pkg::OPC_LD, r[11:8], r[23:16]});
      end
      model_step();
    end
    if (!used[m_pc])
      put_word(m_pc, 16'h0000);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #2 reset_i = 1'b1;
    repeat (8) @(posedge clk);
    #2 reset_i = 1'b0;
    rd_prev = 1'b0;
    check_value("prog_addr_o", 32'(prog_addr_o), 32'(START_ADDR));
    check_value("prog_rd_o", 32'(prog_rd_o), 32'd1);
    check_value("beep_o", 32'(beep_o), 32'd0);
    check_value("halted_o", 32'(halted_o), 32'd0);
  endtask

  // rising edge of the read strobe starts an instruction
  task automatic next_fetch(output chip8_pkg::addr_t addr, output logic halted);
    int   n;
    logic found;
    n      = 0;
    found  = 1'b0;
    halted = 1'b0;
    addr   = '0;
    while (!found && n < FETCH_TIMEOUT)
    begin
      @(negedge clk);
      n++;
      if (halted_o)
      begin
        halted = 1'b1;
        found  = 1'b1;
      end
      else if (prog_rd_o && !rd_prev)
      begin
        addr  = prog_addr_o;
        found = 1'b1;
      end
      rd_prev = prog_rd_o;
    end
    assert (found)
    else report_failure("no instruction fetch before the timeout");
  endtask

  task automatic run_program(input int max_steps);
    chip8_pkg::addr_t a;
    logic             h;
    logic             done;
    int               s;
    model_reset();
    done = 1'b0;
    s    = 0;
    while (!done && s < max_steps)
    begin
      next_fetch(a, h);
      check_value("beep_o", 32'(beep_o), 32'(m_st != '0));
      if (m_halt)
      begin
        check_value("halted_o", 32'(h), 32'd1);
        done = 1'b1;
      end
      else
      begin
        check_value("halted_o", 32'(h), 32'd0);
        check_value("prog_addr_o", 32'(a), 32'(m_pc));
        model_step();
      end
      s++;
    end
  endtask

  task automatic wait_addr(input chip8_pkg::addr_t target);
    chip8_pkg::addr_t a;
    logic             h;
    int               n;
    a = '0;
    n = 0;
    while (a != target && n < 200)
    begin
      next_fetch(a, h);
      assert (!h)
      else report_failure("core halted before reaching the expected loop");
      n++;
    end
    assert (a == target)
    else report_failure("loop address never fetched");
  endtask

  task automatic pulse_vsync();
    @(posedge clk);
    #2 vsync_i = 1'b1;
    repeat (2) @(posedge clk);
    #2 vsync_i = 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic timer_test();
    int r;
    int k;
    int d;
    int p;
    r = $random(seed);
    k = 1 + int'(r[3:0]);
    d = 20 + int'(r[7:4]);
    p = 1 + int'(r[11:8]);
    fill_memory();
    put_word(START_ADDR, {chip8_pkg::OPC_LD, 4'h0, 8'(k)});
    put_word(START_ADDR + 12'd2, {chip8_pkg::OPC_MISC, 4'h0, chip8_pkg::FX_LD_ST});
    put_word(START_ADDR + 12'd4, {chip8_pkg::OPC_LD, 4'h1, 8'd50});
    put_word(START_ADDR + 12'd6, {chip8_pkg::OPC_MISC, 4'h1, chip8_pkg::FX_LD_DT});
    put_word(START_ADDR + 12'd8, {chip8_pkg::OPC_JP, START_ADDR + 12'd8});
    apply_reset();
    wait_addr(START_ADDR + 12'd8);
    check_value("beep_o", 32'(beep_o), 32'd1);
    for (int j = 1; j <= k; j++)
    begin
      pulse_vsync();
      @(negedge clk);
      check_value("beep_o", 32'(beep_o), (j < k) ? 32'd1 : 32'd0);
    end
    // spin on key 0, then read DT and skip over the halt word if it matches
    fill_memory();
    put_word(START_ADDR, {chip8_pkg::OPC_LD, 4'h2, 8'(d)});
    put_word(START_ADDR + 12'd2, {chip8_pkg::OPC_MISC, 4'h2, chip8_pkg::FX_LD_DT});
    put_word(START_ADDR + 12'd4, {chip8_pkg::OPC_LD, 4'h0, 8'h00});
    put_word(START_ADDR + 12'd6, {chip8_pkg::OPC_KEY, 4'h0, chip8_pkg::EX_SKP});
    put_word(START_ADDR + 12'd8, {chip8_pkg::OPC_JP, START_ADDR + 12'd6});
    put_word(START_ADDR + 12'd10, {chip8_pkg::OPC_MISC, 4'h1, chip8_pkg::FX_LD_VX_DT});
    put_word(START_ADDR + 12'd12, {chip8_pkg::OPC_SE, 4'h1, 8'(d - p)});
    put_word(START_ADDR + 12'd14, 16'h0000);
    put_word(START_ADDR + 12'd16, {chip8_pkg::OPC_JP, START_ADDR + 12'd16});
    apply_reset();
    wait_addr(START_ADDR + 12'd6);
    repeat (p) pulse_vsync();
    @(posedge clk);
    #2 keys_i = 16'h0001;
    wait_addr(START_ADDR + 12'd16);
    @(posedge clk);
    #2 keys_i = 16'h0000;
  endtask

  task automatic halt_test();
    int          r;
    logic [15:0] w;
    for (int t = 0; t < 8; t++)
    begin
      r = $random(seed);
      case (r[2:0])
        3'd0:    w = 16'hB123;
        3'd1:    w = 16'hD015;
        3'd2:    w = 16'h8128;
        3'd3:    w = 16'h5121;
        3'd4:    w = 16'hE0FF;
        3'd5:    w = 16'hF033;
        3'd6:    w = 16'h00E0;
        default: w = 16'hC0FF;
      endcase
      fill_memory();
      put_word(START_ADDR, w);
      apply_reset();
      run_program(3);
      repeat (40)
      begin
        @(negedge clk);
        check_value("prog_rd_o", 32'(prog_rd_o), 32'd0);
        check_value("halted_o", 32'(halted_o), 32'd1);
      end
    end
  endtask

  initial
  begin
    int r;
    seed        = 32'h168a5b3b;
    clk         = 1'b0;
    reset_i     = 1'b1;
    vsync_i     = 1'b0;
    keys_i      = '0;
    prog_data_i = '0;
    rd_prev     = 1'b0;
    repeat (12)
    begin
      gen_alu_program(24, 1'b0);
      apply_reset();
      run_program(100);
    end
    repeat (6)
    begin
      gen_flow_program(60);
      apply_reset();
      run_program(70);
    end
    repeat (6)
    begin
      r = $random(seed);
      @(posedge clk);
      #2 keys_i = r[15:0];
      gen_alu_program(16, 1'b1);
      apply_reset();
      run_program(80);
    end
    @(posedge clk);
    #2 keys_i = '0;
    timer_test();
    halt_test();
    $display("Regression passed");
    $finish;
  end

endmodule

// File: chip8_core.f
chip8_pkg.sv
chip8_vreg_if.sv
chip8_regfile.sv
chip8_alu.sv
chip8_timers.sv
chip8_seq.sv
chip8_core.sv
tb_chip8.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_chip8 -f chip8_core.f -o tb_chip8
	./obj_dir/tb_chip8

clean:
	rm -rf obj_dir
